/* compile.f */
hw/cpuPkg.sv
hw/programCounter.sv
hw/instructionDecoder.sv
hw/registerFile.sv
hw/issueStage.sv
hw/aluSimple.sv
hw/executeUnit.sv
hw/cpuCore.sv
verification/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpuCore regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpuTb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VcpuTb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

/* verification/cpuTb.sv */
module cpuTb
    import cpuPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam dataT ResetAddr = 16'h0020;
    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 8;
    localparam int MemDepth = 4096;
    localparam int WriteTimeout = 50;
    localparam int RandSeed = 58;
    localparam writeT IdleWrite = '0;

    logic  clk;
    logic  rstN;
    logic  sysEn;
    dataT  instrAddr;
    instrT instr;
    writeT regWrite;

    instrT mem [MemDepth];
    dataT  model [RegCount];
    writeT expQ [$];
    dataT  progPtr;

    cpuCore #(
        .ResetAddr(ResetAddr)
    ) dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .sysEn    (sysEn),
        .instrAddr(instrAddr),
        .instr    (instr),
        .regWrite (regWrite)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Synchronous instruction memory, one cycle of latency
    always @(posedge clk) begin
        instr <= mem[instrAddr[11:0]];
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    // A write with en low carries no meaningful address or data
    task automatic compareWrite(input writeT got, input writeT want, input string what);
        if (got.en !== want.en ||
            (want.en && (got.addr !== want.addr || got.data !== want.data))) begin
            abortRun($sformatf("ERR %0t: %s got en=%0b r%0d=%h, expected en=%0b r%0d=%h",
                $time, what, got.en, got.addr, got.data, want.en, want.addr, want.data));
        end
    endtask

    task automatic compareAddr(input dataT got, input dataT want, input string what);
        if (got !== want) begin
            abortRun($sformatf("ERR %0t: %s got %h, expected %h", $time, what, got, want));
        end
    endtask

    // Expected results come from the minor-opcode table
    function automatic dataT refAlu(input logic [3:0] minor, input dataT a, input dataT b);
        case (minor)
            4'd0: return a + b;
            4'd1: return a - b;
            4'd2: return a & b;
            4'd3: return a | b;
            4'd4: return a ^ b;
            4'd5: return a << b[3:0];
            4'd6: return a >> b[3:0];
            4'd7: return b;
            default: return '0;
        endcase
    endfunction

    function automatic instrT encode(input logic [3:0] op, input regAddrT a,
                                     input regAddrT b, input logic [3:0] minor);
        instrT i;
        i.opcode = op;
        i.regA = a;
        i.regB = b;
        i.minor = minor;
        return i;
    endfunction

    task automatic put(input instrT i);
        mem[progPtr[11:0]] = i;
        progPtr = progPtr + 16'd1;
    endtask

    task automatic expectWrite(input regAddrT a, input dataT d);
        writeT w;
        w.en = 1'b1;
        w.addr = a;
        w.data = d;
        expQ.push_back(w);
    endtask

    task automatic startProgram();
        for (int i = 0; i < MemDepth; i++) begin
            mem[i] = '0;
        end
        for (int r = 0; r < RegCount; r++) begin
            model[r] = '0;
        end
        expQ.delete();
        progPtr = ResetAddr;
    endtask

    task automatic addLoad(input regAddrT a, input logic [7:0] v);
        put(encode(LOADIMM, a, v[7:4], v[3:0]));
        model[a] = {8'h00, v};
        expectWrite(a, model[a]);
    endtask

    task automatic addAlu(input logic [3:0] minor, input regAddrT a, input regAddrT b);
        put(encode(ALUREG, a, b, minor));
        model[a] = refAlu(minor, model[a], model[b]);
        expectWrite(a, model[a]);
    endtask

    task automatic addAluImm(input logic [3:0] minor, input regAddrT a, input logic [3:0] v);
        put(encode(ALUIMM, a, v, minor));
        model[a] = refAlu(minor, model[a], {12'h000, v});
        expectWrite(a, model[a]);
    endtask

    // Load that must be squashed and never write
    task automatic addSkipped(input regAddrT a);
        put(encode(LOADIMM, a, 4'hE, 4'hE));
    endtask

    task automatic addBranch(input regAddrT a, input logic [7:0] off);
        put(encode(BRZ, a, off[7:4], off[3:0]));
    endtask

    task automatic addJump(input logic [11:0] target);
        put(encode(JMP, target[11:8], target[7:4], target[3:0]));
    endtask

    task automatic endProgram();
        addJump(progPtr[11:0]);
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        sysEn <= 1'b1;
        @(posedge clk);
        repeat (ResetCycles - 1) begin
            @(negedge clk);
            compareWrite(regWrite, IdleWrite, "write during reset");
            compareAddr(instrAddr, ResetAddr, "fetch address during reset");
            @(posedge clk);
        end
        rstN <= 1'b1;
        @(negedge clk);
        compareWrite(regWrite, IdleWrite, "write after reset");
        compareAddr(instrAddr, ResetAddr, "fetch address after reset");
    endtask

    task automatic waitWrite(output writeT got);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!regWrite.en) begin
            cycles++;
            if (cycles > WriteTimeout) begin
                abortRun("Timed out waiting for a register write");
            end
            @(negedge clk);
        end
        got = regWrite;
    endtask

    task automatic checkNextWrite();
        writeT got;
        writeT want;
        want = expQ.pop_front();
        waitWrite(got);
        compareWrite(got, want, "register write");
    endtask

    task automatic idleCheck(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compareWrite(regWrite, IdleWrite, "unexpected write");
        end
    endtask

    task automatic checkWrites();
        while (expQ.size() > 0) begin
            checkNextWrite();
        end
        idleCheck(12);
    endtask

    task automatic checkFetchAddr(input int cycles, input dataT want);
        repeat (cycles) @(negedge clk);
        compareAddr(instrAddr, want, "jump target");
    endtask

    task automatic testReset();
        startProgram();
        endProgram();
        applyReset();
        checkWrites();
    endtask

    // Each result feeds the next one through A or B
    task automatic testAluReg();
        startProgram();
        addLoad(4'd1, 8'($urandom));
        addLoad(4'd2, 8'($urandom));
        for (int m = 0; m < 8; m++) begin
            if (m % 2 == 0) begin
                addAlu(4'(m), 4'd1, 4'd2);
            end else begin
                addAlu(4'(m), 4'd2, 4'd1);
            end
        end
        addAlu(4'd9, 4'd1, 4'd2);
        addAlu(ADD, 4'd1, 4'd2);
        endProgram();
        applyReset();
        checkWrites();
    endtask

    task automatic testAluImm();
        startProgram();
        addLoad(4'd4, 8'($urandom) | 8'h81);
        addAluImm(ADD, 4'd4, 4'hF);
        addAluImm(SHL, 4'd4, 4'd3);
        addAluImm(SUB, 4'd4, 4'd9);
        addAluImm(SHR, 4'd4, 4'd1);
        addAluImm(XOR, 4'd4, 4'hA);
        addAluImm(OR, 4'd4, 4'h5);
        addAluImm(SHL, 4'd4, 4'd0);
        addAluImm(AND, 4'd4, 4'hC);
        addAluImm(PASSB, 4'd4, 4'h7);
        addAluImm(SHL, 4'd4, 4'hF);
        addAluImm(SHR, 4'd4, 4'hF);
        endProgram();
        applyReset();
        checkWrites();
    endtask

    task automatic testBranches();
        // r5 is still zero, so the first branch is taken
        startProgram();
        addBranch(4'd5, 8'h03);
        addSkipped(4'd6);
        addSkipped(4'd7);
        addLoad(4'd8, 8'h33);
        addLoad(4'd9, 8'h01);
        addBranch(4'd9, 8'h03);
        addLoad(4'd10, 8'hA0);
        addLoad(4'd11, 8'hB0);
        addLoad(4'd12, 8'hC0);
        // Counted loop closed by an always-taken branch on the unwritten r0
        addLoad(4'd1, 8'h03);
        put(encode(ALUIMM, 4'd1, 4'd1, SUB));
        put(encode(ALUIMM, 4'd2, 4'd2, ADD));
        addBranch(4'd1, 8'h02);
        addBranch(4'd0, 8'hFD);
        repeat (3) begin
            model[1] = refAlu(SUB, model[1], 16'd1);
            expectWrite(4'd1, model[1]);
            model[2] = refAlu(ADD, model[2], 16'd2);
            expectWrite(4'd2, model[2]);
        end
        addLoad(4'd3, 8'h55);
        endProgram();
        applyReset();
        checkWrites();
    endtask

    task automatic testJal();
        dataT retAddr;
        startProgram();
        addLoad(4'd1, 8'h80);
        put(encode(JAL, 4'd2, 4'd1, 4'd0));
        retAddr = progPtr;
        expectWrite(4'd2, retAddr);
        put(encode(LOADIMM, 4'd3, 4'h3, 4'hC));
        endProgram();
        progPtr = 16'h0080;
        addLoad(4'd5, 8'h5A);
        addJump(12'h090);
        addSkipped(4'd6);
        progPtr = 16'h0090;
        addLoad(4'd7, 8'h77);
        put(encode(JAL, 4'd8, 4'd2, 4'd0));
        expectWrite(4'd8, 16'h0092);
        expectWrite(4'd3, 16'h003C);
        applyReset();
        checkNextWrite();
        checkNextWrite();
        checkFetchAddr(1, 16'h0080);
        checkNextWrite();
        checkFetchAddr(2, 16'h0090);
        checkNextWrite();
        checkNextWrite();
        checkFetchAddr(1, retAddr);
        checkWrites();
    endtask

    task automatic testPause();
        dataT  heldAddr;
        writeT want;
        startProgram();
        for (int r = 1; r <= 8; r++) begin
            addLoad(4'(r), 8'(r * 17));
        end
        endProgram();
        applyReset();
        checkNextWrite();
        checkNextWrite();
        @(posedge clk);
        sysEn <= 1'b0;
        // The third and fourth loads are already past fetch and still retire
        repeat (2) begin
            @(negedge clk);
            want = expQ.pop_front();
            compareWrite(regWrite, want, "drain write");
        end
        // The PC rests on the fifth load while fetch is paused
        heldAddr = ResetAddr + dataT'(4);
        repeat (10) begin
            @(negedge clk);
            compareWrite(regWrite, IdleWrite, "write while paused");
            compareAddr(instrAddr, heldAddr, "fetch address while paused");
        end
        @(posedge clk);
        sysEn <= 1'b1;
        checkWrites();
    endtask

    initial begin
        rstN = 1'b0;
        sysEn = 1'b0;
        instr = '0;
        void'($urandom(RandSeed));
        testReset();
        testAluReg();
        testAluImm();
        testBranches();
        testJal();
        testPause();
        $display("Regression passed");
        $finish;
    end

endmodule

/* hw/cpuCore.sv */
module cpuCore
    import cpuPkg::*;
#(
    parameter dataT ResetAddr = '0
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  sysEn,
    output dataT  instrAddr,
    input  instrT instr,
    output writeT regWrite
);

    logic     fetchValid;
    dataT     fetchAddr;
    decodedT  decoded;
    dataT     readDataA;
    dataT     readDataB;
    issueT    issue;
    redirectT redirect;

    programCounter #(
        .ResetAddr(ResetAddr)
    ) programCounter_i (
        .clk       (clk),
        .rstN      (rstN),
        .sysEn     (sysEn),
        .redirect  (redirect),
        .instrAddr (instrAddr),
        .fetchValid(fetchValid),
        .fetchAddr (fetchAddr)
    );

    instructionDecoder instructionDecoder_i (
        .instr     (instr),
        .fetchValid(fetchValid),
        .decoded   (decoded)
    );

    // Writeback from execute feeds the register file and the observation port
    registerFile registerFile_i (
        .clk      (clk),
        .rstN     (rstN),
        .readAddrA(decoded.regA),
        .readAddrB(decoded.regB),
        .write    (regWrite),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    issueStage issueStage_i (
        .clk      (clk),
        .rstN     (rstN),
        .decoded  (decoded),
        .fetchAddr(fetchAddr),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .redirect (redirect),
        .issue    (issue)
    );

    executeUnit executeUnit_i (
        .issue   (issue),
        .redirect(redirect),
        .write   (regWrite)
    );

endmodule

/* hw/executeUnit.sv */
module executeUnit
    import cpuPkg::*;
(
    input  issueT    issue,
    output redirectT redirect,
    output writeT    write
);

    dataT aluResult;
    dataT linkAddr;
    logic branchTaken;
    logic jumpTaken;

    aluSimple alu_i (
        .op    (issue.aluOp),
        .a     (issue.dataA),
        .b     (issue.dataB),
        .result(aluResult)
    );

    // Branches are relative to their own address
    assign branchTaken = issue.valid && issue.branch && (issue.dataA == '0);
    assign jumpTaken = issue.valid && issue.jump;
    assign linkAddr = issue.instrAddr + dataT'(1);

    always_comb begin
        redirect.taken = branchTaken || jumpTaken;
        if (branchTaken) begin
            redirect.target = issue.instrAddr + issue.offset;
        end else begin
            redirect.target = issue.jumpTarget;
        end
    end

    always_comb begin
        write.en = issue.valid && issue.writeEn;
        write.addr = issue.dest;
        case (issue.wbSrc)
            IMM:     write.data = issue.imm;
            LINK:    write.data = issue.link ? linkAddr : aluResult;
            default: write.data = aluResult;
        endcase
    end

    // A squashed slot must never steer the PC
    always_comb begin
        assert (!redirect.taken || issue.valid);
    end

endmodule

/* hw/aluSimple.sv */
module aluSimple
    import cpuPkg::*;
(
    input  aluOpE op,
    input  dataT  a,
    input  dataT  b,
    output dataT  result
);

    logic [3:0] shamt;

    // Shift distance is the low nibble of B
    assign shamt = b[3:0];

    always_comb begin
        case (op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            XOR: begin
                result = a ^ b;
            end
            SHL: begin
                result = a << shamt;
            end
            SHR: begin
                result = a >> shamt;
            end
            PASSB: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* hw/issueStage.sv */
module issueStage
    import cpuPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  decodedT  decoded,
    input  dataT     fetchAddr,
    input  dataT     readDataA,
    input  dataT     readDataB,
    input  redirectT redirect,
    output issueT    issue
);

    dataT  operandA;
    dataT  operandB;
    issueT nextIssue;

    assign operandA = decoded.readA ? readDataA : '0;

    // Immediate mux on the B side
    always_comb begin
        if (decoded.immEn) begin
            operandB = decoded.imm;
        end else if (decoded.readB) begin
            operandB = readDataB;
        end else begin
            operandB = '0;
        end
    end

    always_comb begin
        nextIssue.valid = decoded.valid && !redirect.taken;
        nextIssue.branch = decoded.branch;
        nextIssue.jump = decoded.jump;
        nextIssue.link = decoded.link;
        nextIssue.aluOp = decoded.aluOp;
        nextIssue.wbSrc = decoded.wbSrc;
        nextIssue.writeEn = decoded.writeEn;
        nextIssue.dest = decoded.regA;
        nextIssue.dataA = operandA;
        nextIssue.dataB = operandB;
        nextIssue.imm = decoded.imm;
        nextIssue.instrAddr = fetchAddr;
        nextIssue.offset = decoded.offset;
        // JAL jumps through regB, JMP carries its target in the immediate
        nextIssue.jumpTarget = (decoded.opcode == JAL) ? operandB : decoded.imm;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issue.valid <= 1'b0;
        end else begin
            issue <= nextIssue;
        end
    end

endmodule

/* hw/registerFile.sv */
module registerFile
    import cpuPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT readAddrA,
    input  regAddrT readAddrB,
    input  writeT   write,
    output dataT    readDataA,
    output dataT    readDataB
);

    dataT regs [RegCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (write.en) begin
            regs[write.addr] <= write.data;
        end
    end

    // Write-through so decode sees the result executing in the same cycle
    always_comb begin
        if (write.en && write.addr == readAddrA) begin
            readDataA = write.data;
        end else begin
            readDataA = regs[readAddrA];
        end

        if (write.en && write.addr == readAddrB) begin
            readDataB = write.data;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

    // Issue register clears under reset, so no write may follow a reset cycle
    noWriteInReset: assert property (
        @(posedge clk) !rstN |=> !write.en
    );

endmodule

/* hw/instructionDecoder.sv */
module instructionDecoder
    import cpuPkg::*;
(
    input  instrT   instr,
    input  logic    fetchValid,
    output decodedT decoded
);

    logic [DataWidth-1:0] raw;

    assign raw = instr;

    always_comb begin
        decoded = '0;
        decoded.valid = fetchValid;
        decoded.opcode = NOP;
        decoded.aluOp = aluOpE'(instr.minor);
        decoded.regA = instr.regA;
        decoded.regB = instr.regB;
        decoded.wbSrc = ALU;
        // Branch displacement spans the regB and minor fields
        decoded.offset = {{(DataWidth - 8){raw[7]}}, raw[7:0]};

        case (instr.opcode)
            NOP: begin
                decoded.opcode = NOP;
            end
            ALUREG: begin
                decoded.opcode = ALUREG;
                decoded.readA = 1'b1;
                decoded.readB = 1'b1;
                decoded.writeEn = 1'b1;
            end
            LOADIMM: begin
                decoded.opcode = LOADIMM;
                decoded.writeEn = 1'b1;
                decoded.wbSrc = IMM;
                decoded.immEn = 1'b1;
                decoded.imm = {{(DataWidth - 8){1'b0}}, raw[7:0]};
            end
            ALUIMM: begin
                decoded.opcode = ALUIMM;
                decoded.readA = 1'b1;
                decoded.writeEn = 1'b1;
                decoded.immEn = 1'b1;
                // Small immediate sits in the regB field
                decoded.imm = {{(DataWidth - 4){1'b0}}, raw[7:4]};
            end
            BRZ: begin
                decoded.opcode = BRZ;
                decoded.readA = 1'b1;
                decoded.branch = 1'b1;
            end
            JMP: begin
                decoded.opcode = JMP;
                decoded.jump = 1'b1;
                decoded.imm = {{(DataWidth - 12){1'b0}}, raw[11:0]};
            end
            JAL: begin
                decoded.opcode = JAL;
                decoded.readB = 1'b1;
                decoded.writeEn = 1'b1;
                decoded.wbSrc = LINK;
                decoded.jump = 1'b1;
                decoded.link = 1'b1;
            end
            default: begin
                // Unknown encodings retire as dead bubbles
                decoded.valid = 1'b0;
            end
        endcase
    end

endmodule

/* hw/programCounter.sv */
module programCounter
    import cpuPkg::*;
#(
    parameter dataT ResetAddr = '0
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     sysEn,
    input  redirectT redirect,
    output dataT     instrAddr,
    output logic     fetchValid,
    output dataT     fetchAddr
);

    dataT pc;

    // A redirect wins over the pause so in-flight jumps still land
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= ResetAddr;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (sysEn) begin
            pc <= pc + dataT'(1);
        end
    end

    // The memory answers one cycle later, so valid and address follow it by one
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= sysEn && !redirect.taken;
        end
    end

    always_ff @(posedge clk) begin
        fetchAddr <= pc;
    end

    assign instrAddr = pc;

    // A paused cycle must not hand a new instruction to decode
    pauseBlocksFetch: assert property (
        @(posedge clk) disable iff (!rstN)
        (!sysEn && !redirect.taken) |=> !fetchValid
    );

endmodule

/* hw/cpuPkg.sv */
package cpuPkg;

    localparam int DataWidth = 16;
    localparam int RegCount = 16;
    localparam int RegAddrWidth = $clog2(RegCount);

    typedef logic [DataWidth-1:0] dataT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    // Major opcodes, bits 15 to 12 of the instruction
    typedef enum logic [3:0] {
        NOP     = 4'd0,
        ALUREG  = 4'd1,
        LOADIMM = 4'd2,
        ALUIMM  = 4'd3,
        BRZ     = 4'd4,
        JMP     = 4'd5,
        JAL     = 4'd6
    } opcodeE;

    // Minor opcodes; 8 to 15 give a zero result
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        AND   = 4'd2,
        OR    = 4'd3,
        XOR   = 4'd4,
        SHL   = 4'd5,
        SHR   = 4'd6,
        PASSB = 4'd7
    } aluOpE;

    typedef enum logic [1:0] {
        ALU  = 2'd0,
        IMM  = 2'd1,
        LINK = 2'd2
    } wbSrcE;

    // Raw opcode kept as plain bits so unknown encodings survive to the decoder
    typedef struct packed {
        logic [3:0] opcode;
        regAddrT    regA;
        regAddrT    regB;
        logic [3:0] minor;
    } instrT;

    typedef struct packed {
        logic    valid;
        opcodeE  opcode;
        aluOpE   aluOp;
        regAddrT regA;
        regAddrT regB;
        logic    readA;
        logic    readB;
        logic    writeEn;
        wbSrcE   wbSrc;
        logic    immEn;
        dataT    imm;
        logic    branch;
        logic    jump;
        logic    link;
        dataT    offset;
    } decodedT;

    typedef struct packed {
        logic    valid;
        logic    branch;
        logic    jump;
        logic    link;
        aluOpE   aluOp;
        wbSrcE   wbSrc;
        logic    writeEn;
        regAddrT dest;
        dataT    dataA;
        dataT    dataB;
        dataT    imm;
        dataT    instrAddr;
        dataT    offset;
        dataT    jumpTarget;
    } issueT;

    typedef struct packed {
        logic    en;
        regAddrT addr;
        dataT    data;
    } writeT;

    typedef struct packed {
        logic taken;
        dataT target;
    } redirectT;

endpackage
